// File: proxy_probe.f
+incdir+logic
logic/proxy_probe_pkg.sv
logic/ram_sp.sv
logic/reg_decoder.sv
logic/info_reg_block.sv
logic/mem_proxy.sv
logic/proxy_probe.sv
verification/proxy_probe_tb.sv

// File: Makefile
# Verilator build and run for proxy_probe

VERILATOR ?= verilator
TOP       ?= proxy_probe_tb
FILELIST  ?= proxy_probe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) logic/proxy_probe_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/proxy_probe_tb.sv
`timescale 1ns/10ps

`include "proxy_probe_config.svh"

module proxy_probe_tb import proxy_probe_pkg::*; ();
    // About twice the longest run, with every busy poll at its limit
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int POLL_LIMIT     = 16;
    localparam int N_WORDS        = 32;
    localparam reg_data_t EXP_ID_PRE  = " PRE";
    localparam reg_data_t EXP_ID_POST = "POST";

    logic      clk;
    logic      srst;
    reg_req_t  req;
    reg_rsp_t  rsp;
    int        cycle_cnt;
    int        check_fails;
    int        test_base;
    int        tests_passed;
    int        tests_failed;
    string     test_name;
    reg_data_t exp_mem [`PP_MEM_DEPTH];

    proxy_probe dut (.clk(clk), .srst(srst), .i_req(req), .o_rsp(rsp));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, stuck in test %s", cycle_cnt, test_name);
            $display("Something failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Bus protocol checks
    // ----------------------------------------
    a_ack_next : assert property (@(posedge clk) disable iff (srst)
        (req.wr || req.rd) |=> rsp.ack)
        else begin
            $display("ERROR: no ack one cycle after a strobe in test %s", test_name);
            check_fails++;
        end

    // Also covers ack staying low after reset until the first request
    a_ack_has_strobe : assert property (@(posedge clk) disable iff (srst)
        rsp.ack |-> $past(req.wr || req.rd))
        else begin
            $display("ERROR: ack without a request in test %s", test_name);
            check_fails++;
        end

    function automatic reg_addr_t make_addr(input logic [1:0] region, input reg_addr_t offset);
        return {region, offset[OFFSET_WID-1:0]};
    endfunction

    task automatic expect_eq(input string what, input reg_data_t exp, input reg_data_t act);
        assert (act === exp)
        else begin
            $display("MISMATCH %s %s: expected %h actual %h", test_name, what, exp, act);
            check_fails++;
        end
    endtask

    // Called at a clock edge, returns at the edge where ack is seen
    task automatic access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                          output reg_data_t rdata, output logic err);
        req.wr    <= wr;
        req.rd    <= !wr;
        req.addr  <= addr;
        req.wdata <= wdata;
        @(posedge clk);
        req <= '0;
        do begin
            @(posedge clk);
        end while (!rsp.ack);
        rdata = rsp.rdata;
        err   = rsp.error;
    endtask

    task automatic wait_not_busy();
        reg_data_t status;
        logic      err;
        int        polls;
        polls = 0;
        do begin
            access(1'b0, make_addr(`PP_REGION_MEM, MEM_STATUS), '0, status, err);
            polls++;
        end while (status[0] && polls < POLL_LIMIT);
        assert (!status[0])
        else begin
            $display("ERROR: memory proxy still busy after %0d polls in test %s", polls, test_name);
            check_fails++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_base = check_fails;
    endtask

    task automatic finish_test();
        if (check_fails == test_base) begin
            tests_passed++;
            $display("PASS %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %s", test_name);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        reg_data_t rdata;
        reg_data_t word;
        trigger_t  last_trig;
        logic      err;
        int        n_trig;
        mem_addr_t start;
        mem_addr_t probe;

        clk = 1'b0;
        srst = 1'b1;
        req = '0;
        cycle_cnt = 0;
        check_fails = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name = "reset";
        void'($urandom(32'h8249_0bf0));
        repeat (5) @(posedge clk);
        srst <= 1'b0;
        @(posedge clk);

        start_test("reset_idle");
        repeat (4) begin
            @(posedge clk);
            expect_eq("ack", '0, reg_data_t'(rsp.ack));
        end
        finish_test();

        start_test("identity");
        access(1'b0, make_addr(`PP_REGION_INFO, INFO_ID_PRE), '0, rdata, err);
        expect_eq("id_pre", EXP_ID_PRE, rdata);
        expect_eq("id_pre error", '0, reg_data_t'(err));
        access(1'b0, make_addr(`PP_REGION_INFO, INFO_ID_POST), '0, rdata, err);
        expect_eq("id_post", EXP_ID_POST, rdata);
        expect_eq("id_post error", '0, reg_data_t'(err));
        finish_test();

        start_test("trigger");
        n_trig = 4 + int'($urandom % 4);
        for (int i = 0; i < n_trig; i++) begin
            word = $urandom;
            last_trig = word[15:0];
            access(1'b1, make_addr(`PP_REGION_INFO, INFO_TRIGGER), word, rdata, err);
            expect_eq("trigger write error", '0, reg_data_t'(err));
        end
        access(1'b0, make_addr(`PP_REGION_INFO, INFO_TRIGGER), '0, rdata, err);
        expect_eq("trigger", {16'h0, last_trig}, rdata);
        access(1'b0, make_addr(`PP_REGION_INFO, INFO_STATUS), '0, rdata, err);
        expect_eq("status", {16'(n_trig), last_trig}, rdata);
        finish_test();

        start_test("error_acks");
        access(1'b1, make_addr(`PP_REGION_INFO, INFO_STATUS), $urandom, rdata, err);
        expect_eq("status write error", 32'd1, reg_data_t'(err));
        access(1'b0, make_addr(`PP_REGION_INFO, 'h17), '0, rdata, err);
        expect_eq("unknown offset error", 32'd1, reg_data_t'(err));
        expect_eq("unknown offset rdata", '0, rdata);
        for (int r = 2; r < 4; r++) begin
            access(1'b1, make_addr(2'(r), INFO_TRIGGER), $urandom, rdata, err);
            expect_eq("unmapped write error", 32'd1, reg_data_t'(err));
            access(1'b0, make_addr(2'(r), INFO_TRIGGER), '0, rdata, err);
            expect_eq("unmapped read error", 32'd1, reg_data_t'(err));
            expect_eq("unmapped read rdata", '0, rdata);
        end
        access(1'b0, make_addr(`PP_REGION_INFO, INFO_TRIGGER), '0, rdata, err);
        expect_eq("trigger kept", {16'h0, last_trig}, rdata);
        access(1'b0, make_addr(`PP_REGION_INFO, INFO_STATUS), '0, rdata, err);
        expect_eq("status kept", {16'(n_trig), last_trig}, rdata);
        finish_test();

        // Start near the top so the auto-increment wraps
        start_test("mem_stream");
        start = mem_addr_t'(230 + ($urandom % 20));
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_ADDR), reg_data_t'(start), rdata, err);
        for (int i = 0; i < N_WORDS; i++) begin
            word = $urandom;
            exp_mem[mem_addr_t'(start + mem_addr_t'(i))] = word;
            access(1'b1, make_addr(`PP_REGION_MEM, MEM_WDATA), word, rdata, err);
            access(1'b1, make_addr(`PP_REGION_MEM, MEM_CMD), CMD_WRITE, rdata, err);
            expect_eq("write cmd error", '0, reg_data_t'(err));
            wait_not_busy();
        end
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_ADDR), reg_data_t'(start), rdata, err);
        for (int i = 0; i < N_WORDS; i++) begin
            access(1'b1, make_addr(`PP_REGION_MEM, MEM_CMD), CMD_READ, rdata, err);
            expect_eq("read cmd error", '0, reg_data_t'(err));
            wait_not_busy();
            access(1'b0, make_addr(`PP_REGION_MEM, MEM_RDATA), '0, rdata, err);
            expect_eq("mem word", exp_mem[mem_addr_t'(start + mem_addr_t'(i))], rdata);
        end
        access(1'b0, make_addr(`PP_REGION_MEM, MEM_ADDR), '0, rdata, err);
        expect_eq("final addr", reg_data_t'(mem_addr_t'(start + N_WORDS)), rdata);
        finish_test();

        // Second command lands while the read is still capturing
        start_test("cmd_reject");
        probe = start;
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_ADDR), reg_data_t'(probe), rdata, err);
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_WDATA), ~exp_mem[probe], rdata, err);
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_CMD), CMD_READ, rdata, err);
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_CMD), CMD_WRITE, rdata, err);
        expect_eq("busy cmd error", 32'd1, reg_data_t'(err));
        wait_not_busy();
        access(1'b0, make_addr(`PP_REGION_MEM, MEM_RDATA), '0, rdata, err);
        expect_eq("busy read word", exp_mem[probe], rdata);
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_CMD), 32'h7, rdata, err);
        expect_eq("unknown cmd error", 32'd1, reg_data_t'(err));
        access(1'b0, make_addr(`PP_REGION_MEM, MEM_ADDR), '0, rdata, err);
        expect_eq("addr kept", reg_data_t'(mem_addr_t'(probe + 1'b1)), rdata);
        access(1'b1, make_addr(`PP_REGION_MEM, MEM_ADDR), reg_data_t'(probe), rdata, err);
        for (int i = 0; i < 2; i++) begin
            access(1'b1, make_addr(`PP_REGION_MEM, MEM_CMD), CMD_READ, rdata, err);
            wait_not_busy();
            access(1'b0, make_addr(`PP_REGION_MEM, MEM_RDATA), '0, rdata, err);
            expect_eq("mem kept", exp_mem[mem_addr_t'(probe + mem_addr_t'(i))], rdata);
        end
        finish_test();

        $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, check_fails);
        if (tests_failed == 0 && check_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : proxy_probe_tb

// File: logic/proxy_probe.sv
`timescale 1ns/10ps

`include "proxy_probe_config.svh"

module proxy_probe import proxy_probe_pkg::*; (
    input  logic     clk,
    input  logic     srst,
    input  reg_req_t i_req,
    output reg_rsp_t o_rsp
);
    reg_req_t  info_req;
    reg_rsp_t  info_rsp;
    reg_req_t  mem_req;
    reg_rsp_t  mem_rsp;

    logic      ram_en;
    logic      ram_we;
    mem_addr_t ram_addr;
    reg_data_t ram_wdata;
    reg_data_t ram_rdata;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    reg_decoder i_reg_decoder (
        .clk        ( clk ),
        .srst       ( srst ),
        .i_req      ( i_req ),
        .o_rsp      ( o_rsp ),
        .o_info_req ( info_req ),
        .i_info_rsp ( info_rsp ),
        .o_mem_req  ( mem_req ),
        .i_mem_rsp  ( mem_rsp )
    );

    // Identity, trigger and status
    info_reg_block i_info_reg_block (
        .clk   ( clk ),
        .srst  ( srst ),
        .i_req ( info_req ),
        .o_rsp ( info_rsp )
    );

    // ----------------------------------------
    // Memory proxy and RAM
    // ----------------------------------------
    mem_proxy i_mem_proxy (
        .clk         ( clk ),
        .srst        ( srst ),
        .i_req       ( mem_req ),
        .o_rsp       ( mem_rsp ),
        .o_ram_en    ( ram_en ),
        .o_ram_we    ( ram_we ),
        .o_ram_addr  ( ram_addr ),
        .o_ram_wdata ( ram_wdata ),
        .i_ram_rdata ( ram_rdata )
    );

    ram_sp #(
        .DEPTH ( `PP_MEM_DEPTH ),
        .WIDTH ( `PP_DATA_WID )
    ) i_ram_sp (
        .clk     ( clk ),
        .i_en    ( ram_en ),
        .i_we    ( ram_we ),
        .i_addr  ( ram_addr ),
        .i_wdata ( ram_wdata ),
        .o_rdata ( ram_rdata )
    );

endmodule : proxy_probe

// File: logic/mem_proxy.sv
`timescale 1ns/10ps

`include "proxy_probe_config.svh"

module mem_proxy import proxy_probe_pkg::*; (
    input  logic      clk,
    input  logic      srst,
    input  reg_req_t  i_req,
    output reg_rsp_t  o_rsp,
    output logic      o_ram_en,
    output logic      o_ram_we,
    output mem_addr_t o_ram_addr,
    output reg_data_t o_ram_wdata,
    input  reg_data_t i_ram_rdata
);
    mem_state_t state;
    mem_addr_t  addr_q;
    mem_addr_t  addr_next;
    reg_data_t  wdata_q;
    reg_data_t  rdata_q;
    reg_rsp_t   rsp_q;
    logic       busy;

    assign busy      = (state != MEM_IDLE);
    // Auto-increment wraps at the memory depth
    assign addr_next = (addr_q == mem_addr_t'(`PP_MEM_DEPTH - 1)) ? '0 : addr_q + 1'b1;

    always_ff @(posedge clk) begin
        if (srst) begin
            state   <= MEM_IDLE;
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
            rsp_q   <= '0;
        end else begin
            // ----------------------------------------
            // Command FSM
            // ----------------------------------------
            case (state)
                MEM_WRITE: begin
                    addr_q <= addr_next;
                    state  <= MEM_IDLE;
                end
                MEM_READ_WAIT: state <= MEM_READ_CAPTURE;
                MEM_READ_CAPTURE: begin
                    rdata_q <= i_ram_rdata;
                    addr_q  <= addr_next;
                    state   <= MEM_IDLE;
                end
                default: state <= MEM_IDLE;
            endcase

            rsp_q.ack   <= i_req.wr || i_req.rd;
            rsp_q.error <= 1'b0;
            rsp_q.rdata <= '0;

            // ----------------------------------------
            // Window register access
            // ----------------------------------------
            // A host write to MEM_ADDR takes priority over the auto-increment
            if (i_req.wr) begin
                case (i_req.addr)
                    MEM_ADDR:  addr_q  <= mem_addr_t'(i_req.wdata);
                    MEM_WDATA: wdata_q <= i_req.wdata;
                    MEM_CMD: begin
                        if (busy) begin
                            rsp_q.error <= 1'b1;
                        end else if (i_req.wdata == CMD_WRITE) begin
                            state <= MEM_WRITE;
                        end else if (i_req.wdata == CMD_READ) begin
                            state <= MEM_READ_WAIT;
                        end else begin
                            rsp_q.error <= 1'b1;
                        end
                    end
                    default: rsp_q.error <= 1'b1;
                endcase
            end

            if (i_req.rd) begin
                case (i_req.addr)
                    MEM_ADDR:   rsp_q.rdata <= reg_data_t'(addr_q);
                    MEM_WDATA:  rsp_q.rdata <= wdata_q;
                    MEM_CMD:    rsp_q.rdata <= '0;
                    MEM_RDATA:  rsp_q.rdata <= rdata_q;
                    MEM_STATUS: rsp_q.rdata <= reg_data_t'(busy);
                    default:    rsp_q.error <= 1'b1;
                endcase
            end
        end
    end

    assign o_rsp = rsp_q;

    // RAM port, address and data held in the window registers during a command
    assign o_ram_en    = (state == MEM_WRITE) || (state == MEM_READ_WAIT);
    assign o_ram_we    = (state == MEM_WRITE);
    assign o_ram_addr  = addr_q;
    assign o_ram_wdata = wdata_q;

    // RAM is only touched in the cycle after an accepted command
    a_en_active : assert property (@(posedge clk) disable iff (srst)
        o_ram_en |-> $past(i_req.wr && i_req.addr == MEM_CMD && !busy));

    a_we_in_write : assert property (@(posedge clk) disable iff (srst)
        o_ram_we |-> $past(i_req.wr && i_req.addr == MEM_CMD && i_req.wdata == CMD_WRITE));

endmodule : mem_proxy

// File: logic/info_reg_block.sv
`timescale 1ns/10ps

`include "proxy_probe_config.svh"

module info_reg_block import proxy_probe_pkg::*; (
    input  logic     clk,
    input  logic     srst,
    input  reg_req_t i_req,
    output reg_rsp_t o_rsp
);
    trigger_t    trigger_q;
    trigger_t    trig_capture_q;
    logic [15:0] trig_count_q;
    reg_rsp_t    rsp_q;

    always_ff @(posedge clk) begin
        if (srst) begin
            trigger_q      <= '0;
            trig_capture_q <= '0;
            trig_count_q   <= '0;
            rsp_q          <= '0;
        end else begin
            rsp_q.ack   <= i_req.wr || i_req.rd;
            rsp_q.error <= 1'b0;
            rsp_q.rdata <= '0;

            // ----------------------------------------
            // Writes
            // ----------------------------------------
            if (i_req.wr) begin
                case (i_req.addr)
                    INFO_TRIGGER: begin
                        trigger_q      <= trigger_t'(i_req.wdata);
                        trig_capture_q <= trigger_t'(i_req.wdata);
                        // Count wraps at 16 bits
                        trig_count_q   <= trig_count_q + 1'b1;
                    end
                    // Identity and status words are read-only
                    default: rsp_q.error <= 1'b1;
                endcase
            end

            // ----------------------------------------
            // Reads
            // ----------------------------------------
            if (i_req.rd) begin
                case (i_req.addr)
                    INFO_ID_PRE:  rsp_q.rdata <= reg_data_t'(`PP_ID_PRE);
                    INFO_ID_POST: rsp_q.rdata <= reg_data_t'(`PP_ID_POST);
                    INFO_TRIGGER: rsp_q.rdata <= reg_data_t'(trigger_q);
                    INFO_STATUS:  rsp_q.rdata <= reg_data_t'({trig_count_q, trig_capture_q});
                    default:      rsp_q.error <= 1'b1;
                endcase
            end
        end
    end

    assign o_rsp = rsp_q;

    // One strobe at a time, acked next cycle before any new request
    a_ack_next : assert property (@(posedge clk) disable iff (srst)
        (i_req.wr || i_req.rd) |-> !(i_req.wr && i_req.rd)
            ##1 (o_rsp.ack && !i_req.wr && !i_req.rd));

endmodule : info_reg_block

// File: logic/reg_decoder.sv
`timescale 1ns/10ps

`include "proxy_probe_config.svh"

module reg_decoder import proxy_probe_pkg::*; (
    input  logic     clk,
    input  logic     srst,
    input  reg_req_t i_req,
    output reg_rsp_t o_rsp,
    output reg_req_t o_info_req,
    input  reg_rsp_t i_info_rsp,
    output reg_req_t o_mem_req,
    input  reg_rsp_t i_mem_rsp
);
    logic [REGION_WID-1:0] region;
    logic                  sel_info;
    logic                  sel_mem;
    logic                  unmapped;
    logic                  err_ack;

    // ----------------------------------------
    // Region decode and request routing
    // ----------------------------------------
    assign region   = i_req.addr[`PP_ADDR_WID-1:OFFSET_WID];
    assign sel_info = (region == `PP_REGION_INFO);
    assign sel_mem  = (region == `PP_REGION_MEM);
    assign unmapped = (i_req.wr || i_req.rd) && !sel_info && !sel_mem;

    always_comb begin
        o_info_req       = i_req;
        o_info_req.wr    = i_req.wr && sel_info;
        o_info_req.rd    = i_req.rd && sel_info;
        o_info_req.addr  = reg_addr_t'(i_req.addr[OFFSET_WID-1:0]);

        o_mem_req        = i_req;
        o_mem_req.wr     = i_req.wr && sel_mem;
        o_mem_req.rd     = i_req.rd && sel_mem;
        o_mem_req.addr   = reg_addr_t'(i_req.addr[OFFSET_WID-1:0]);
    end

    // Unmapped regions answer with an error, one cycle later like the targets
    always_ff @(posedge clk) begin
        if (srst) begin
            err_ack <= 1'b0;
        end else begin
            err_ack <= unmapped;
        end
    end

    // ----------------------------------------
    // Response merge
    // ----------------------------------------
    assign o_rsp.ack   = i_info_rsp.ack || i_mem_rsp.ack || err_ack;
    assign o_rsp.error = (i_info_rsp.ack && i_info_rsp.error)
                       || (i_mem_rsp.ack && i_mem_rsp.error)
                       || err_ack;
    assign o_rsp.rdata = (i_info_rsp.ack ? i_info_rsp.rdata : '0)
                       | (i_mem_rsp.ack ? i_mem_rsp.rdata : '0);

    // Only one request is in flight, so at most one source answers
    a_single_ack : assert property (@(posedge clk) disable iff (srst)
        $onehot0({i_info_rsp.ack, i_mem_rsp.ack, err_ack}));

endmodule : reg_decoder

// File: logic/ram_sp.sv
`timescale 1ns/10ps

module ram_sp #(
    parameter int DEPTH = 256,
    parameter int WIDTH = 32
) (
    input  logic                                   clk,
    input  logic                                   i_en,
    input  logic                                   i_we,
    input  logic [(DEPTH > 1 ? $clog2(DEPTH) : 1)-1:0] i_addr,
    input  logic [WIDTH-1:0]                       i_wdata,
    output logic [WIDTH-1:0]                       o_rdata
);
    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] rdata_q;

    // Read data follows the enabled address by one cycle
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end
            rdata_q <= mem[i_addr];
        end
    end

    assign o_rdata = rdata_q;

endmodule : ram_sp

// File: logic/proxy_probe_pkg.sv
package proxy_probe_pkg;

`include "proxy_probe_config.svh"

    // ----------------------------------------
    // Address split
    // ----------------------------------------
    localparam int REGION_WID = 2;
    localparam int OFFSET_WID = `PP_ADDR_WID - REGION_WID;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [`PP_ADDR_WID-1:0] reg_addr_t;
    typedef logic [`PP_DATA_WID-1:0] reg_data_t;
    typedef logic [$clog2(`PP_MEM_DEPTH)-1:0] mem_addr_t;
    typedef logic [15:0] trigger_t;

    // Register bus request, wr and rd are single-cycle strobes
    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // Register bus response, error and rdata valid with ack
    typedef struct packed {
        logic      ack;
        logic      error;
        reg_data_t rdata;
    } reg_rsp_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WRITE,
        MEM_READ_WAIT,
        MEM_READ_CAPTURE
    } mem_state_t;

    // Info block register offsets
    localparam reg_addr_t INFO_ID_PRE  = 'd0;
    localparam reg_addr_t INFO_ID_POST = 'd1;
    localparam reg_addr_t INFO_TRIGGER = 'd2;
    localparam reg_addr_t INFO_STATUS  = 'd3;

    // Memory proxy register offsets
    localparam reg_addr_t MEM_ADDR   = 'd0;
    localparam reg_addr_t MEM_WDATA  = 'd1;
    localparam reg_addr_t MEM_CMD    = 'd2;
    localparam reg_addr_t MEM_RDATA  = 'd3;
    localparam reg_addr_t MEM_STATUS = 'd4;

    // Memory proxy command codes
    localparam reg_data_t CMD_WRITE = 'd1;
    localparam reg_data_t CMD_READ  = 'd2;

endpackage : proxy_probe_pkg

// File: logic/proxy_probe_config.svh
`ifndef PROXY_PROBE_CONFIG_SVH
`define PROXY_PROBE_CONFIG_SVH

// Register bus widths
`define PP_ADDR_WID 10
`define PP_DATA_WID 32

// Proxied RAM depth in words
`define PP_MEM_DEPTH 256

// Identity words, ASCII " PRE" and "POST"
`define PP_ID_PRE  32'h2050_5245
`define PP_ID_POST 32'h504F_5354

// Region numbers in the top address bits, regions 2 and 3 unmapped
`define PP_REGION_INFO 2'd0
`define PP_REGION_MEM  2'd1

`endif
